// ==== hw/matmul_pkg.sv ====
`default_nettype none

package matmul_pkg;

  // array and memory geometry
  localparam int DIM = 4;
  localparam int ELEM_W = 16;
  localparam int ADDR_W = 7;
  localparam int MEM_DEPTH = 2 ** ADDR_W;
  localparam int MAC_LATENCY = 2;

  // the tile settles at count 3*(DIM-1) + 1 + MAC_LATENCY, capture leaves two spare cycles
  localparam int CAPTURE_CYCLE = 3 * DIM + MAC_LATENCY;
  localparam int DONE_CYCLES = CAPTURE_CYCLE + DIM;
  // input register, memory read, output register
  localparam int READ_LATENCY = 3;
  localparam int CNT_W = $clog2(DONE_CYCLES + 1);

  typedef logic [ELEM_W-1:0] elem_t;
  typedef logic [ADDR_W-1:0] addr_t;
  // lane k sits at bits ELEM_W*k and up
  typedef elem_t [DIM-1:0] row_t;
  typedef row_t [DIM-1:0] tile_t;
  typedef logic [CNT_W-1:0] cnt_t;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_RUN,
    SEQ_DONE
  } seq_state_e;

endpackage

`default_nettype wire

// ==== hw/operand_feed.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_feed (
  input  wire                     clk,
  input  wire                     reset,
  input  wire                     i_load,
  input  wire                     i_we,
  input  wire matmul_pkg::addr_t  i_wr_addr,
  input  wire matmul_pkg::row_t   i_wr_data,
  input  wire                     i_feed_en,
  input  wire                     i_run,
  output wire matmul_pkg::row_t   o_lanes
);

  matmul_pkg::row_t  mem [matmul_pkg::MEM_DEPTH];
  matmul_pkg::row_t  rd_data;
  matmul_pkg::row_t  head;
  matmul_pkg::addr_t feed_addr;
  logic              rd_valid;

  // host writes only in load mode, the feed side reads every cycle
  always_ff @(posedge clk) begin
    if (i_load && i_we) begin
      mem[i_wr_addr] <= i_wr_data;
    end
    rd_data <= mem[feed_addr];
  end

  // feed address walks 0, 1, 2 ... during the feed window
  always_ff @(posedge clk) begin
    if (reset || !i_run) begin
      feed_addr <= '0;
      rd_valid  <= 1'b0;
    end else begin
      rd_valid <= i_feed_en;
      if (i_feed_en) begin
        feed_addr <= feed_addr + 1'b1;
      end
    end
  end

  // lanes carry zero outside the window so accumulators stay put
  assign head = rd_valid ? rd_data : '0;

  // lane k enters the grid k cycles late
  for (genvar k = 0; k < matmul_pkg::DIM; k++) begin : g_lane
    if (k == 0) begin : g_direct
      assign o_lanes[k] = head[k];
    end else begin : g_delay
      matmul_pkg::elem_t dly [k];

      always_ff @(posedge clk) begin
        if (reset || !i_run) begin
          for (int i = 0; i < k; i++) begin
            dly[i] <= '0;
          end
        end else begin
          dly[0] <= head[k];
          for (int i = 1; i < k; i++) begin
            dly[i] <= dly[i-1];
          end
        end
      end

      assign o_lanes[k] = dly[k-1];
    end
  end

endmodule

`default_nettype wire

// ==== hw/mac_pe.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_pe (
  input  wire                     clk,
  input  wire                     reset,
  input  wire                     i_clear,
  input  wire matmul_pkg::elem_t  i_a,
  input  wire matmul_pkg::elem_t  i_b,
  output matmul_pkg::elem_t       o_a,
  output matmul_pkg::elem_t       o_b,
  output matmul_pkg::elem_t       o_acc
);

  matmul_pkg::elem_t prod;

  // a moves right, b moves down, one hop per cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      o_a <= '0;
      o_b <= '0;
    end else begin
      o_a <= i_a;
      o_b <= i_b;
    end
  end

  // stage 1 registers the product, stage 2 accumulates
  // both wrap modulo 2^16
  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      prod  <= '0;
      o_acc <= '0;
    end else begin
      prod  <= i_a * i_b;
      o_acc <= o_acc + prod;
    end
  end

endmodule

`default_nettype wire

// ==== hw/systolic_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module systolic_array (
  input  wire                     clk,
  input  wire                     reset,
  input  wire                     i_clear,
  input  wire matmul_pkg::row_t   i_a_lanes,
  input  wire matmul_pkg::row_t   i_b_lanes,
  output wire matmul_pkg::tile_t  o_tile
);

  // a_link[r][c] feeds the cell at (r, c) from its left neighbour
  // b_link[r][c] feeds the cell at (r, c) from above
  matmul_pkg::elem_t a_link [matmul_pkg::DIM][matmul_pkg::DIM+1];
  matmul_pkg::elem_t b_link [matmul_pkg::DIM+1][matmul_pkg::DIM];

  // A lanes enter from the left edge, one per row
  for (genvar r = 0; r < matmul_pkg::DIM; r++) begin : g_a_edge
    assign a_link[r][0] = i_a_lanes[r];
  end

  // B lanes enter from the top edge, one per column
  for (genvar c = 0; c < matmul_pkg::DIM; c++) begin : g_b_edge
    assign b_link[0][c] = i_b_lanes[c];
  end

  for (genvar r = 0; r < matmul_pkg::DIM; r++) begin : g_row
    for (genvar c = 0; c < matmul_pkg::DIM; c++) begin : g_col
      mac_pe u_pe (
        .clk     (clk),
        .reset   (reset),
        .i_clear (i_clear),
        .i_a     (a_link[r][c]),
        .i_b     (b_link[r][c]),
        .o_a     (a_link[r][c+1]),
        .o_b     (b_link[r+1][c]),
        .o_acc   (o_tile[r][c])
      );
    end
  end

endmodule

`default_nettype wire

// ==== hw/matmul_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module matmul_sequencer (
  input  wire   clk,
  input  wire   reset,
  input  wire   i_start,
  output logic  o_feed_en,
  output logic  o_clear,
  output logic  o_capture,
  output logic  o_done
);

  matmul_pkg::seq_state_e state;
  matmul_pkg::cnt_t       count;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= matmul_pkg::SEQ_IDLE;
      count <= '0;
    end else begin
      case (state)
        matmul_pkg::SEQ_IDLE: begin
          count <= '0;
          if (i_start) begin
            state <= matmul_pkg::SEQ_RUN;
          end
        end
        matmul_pkg::SEQ_RUN: begin
          if (!i_start) begin
            state <= matmul_pkg::SEQ_IDLE;
            count <= '0;
          end else begin
            count <= count + 1'b1;
            // the edge that would bring count to DONE_CYCLES moves to done
            if (count == matmul_pkg::cnt_t'(matmul_pkg::DONE_CYCLES - 1)) begin
              state <= matmul_pkg::SEQ_DONE;
            end
          end
        end
        default: begin
          // hold done until start is dropped
          if (!i_start) begin
            state <= matmul_pkg::SEQ_IDLE;
            count <= '0;
          end
        end
      endcase
    end
  end

  assign o_clear   = (state == matmul_pkg::SEQ_IDLE);
  assign o_feed_en = (state == matmul_pkg::SEQ_RUN) &&
                     (count < matmul_pkg::cnt_t'(matmul_pkg::DIM));
  assign o_capture = (state == matmul_pkg::SEQ_RUN) &&
                     (count == matmul_pkg::cnt_t'(matmul_pkg::CAPTURE_CYCLE));
  assign o_done    = (state == matmul_pkg::SEQ_DONE);

endmodule

`default_nettype wire

// ==== hw/result_drain.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_drain (
  input  wire                     clk,
  input  wire                     reset,
  input  wire                     i_capture,
  input  wire matmul_pkg::tile_t  i_tile,
  input  wire                     i_read,
  input  wire matmul_pkg::addr_t  i_rd_addr,
  output matmul_pkg::row_t        o_rd_data
);

  matmul_pkg::row_t  mem [matmul_pkg::MEM_DEPTH];
  matmul_pkg::tile_t tile_q;
  matmul_pkg::row_t  mem_q;
  matmul_pkg::addr_t wr_addr;
  logic [1:0]        row_idx;
  logic              wr_active;
  logic              rd_valid;

  // snapshot of the accumulator grid
  always_ff @(posedge clk) begin
    if (i_capture) begin
      tile_q <= i_tile;
    end
  end

  // row walk, one C row per cycle after the capture
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_active <= 1'b0;
      row_idx   <= '0;
    end else if (i_capture) begin
      wr_active <= 1'b1;
      row_idx   <= '0;
    end else if (wr_active) begin
      row_idx <= row_idx + 1'b1;
      if (row_idx == '1) begin
        wr_active <= 1'b0;
      end
    end
  end

  // C row r lives at address r
  assign wr_addr = matmul_pkg::addr_t'(row_idx);

  // drain writes win over host reads
  always_ff @(posedge clk) begin
    if (wr_active) begin
      mem[wr_addr] <= tile_q[row_idx];
    end else if (i_read) begin
      mem_q <= mem[i_rd_addr];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= i_read && !wr_active;
    end
  end

  // registered read port toward the host
  always_ff @(posedge clk) begin
    if (rd_valid) begin
      o_rd_data <= mem_q;
    end
  end

endmodule

`default_nettype wire

// ==== hw/matmul_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module matmul_top (
  input  wire                     clk,
  input  wire                     reset,
  input  wire                     i_load,
  input  wire                     i_we_a,
  input  wire                     i_we_b,
  input  wire                     i_read,
  input  wire                     i_start,
  input  wire matmul_pkg::addr_t  i_addr,
  input  wire matmul_pkg::row_t   i_wr_data,
  output wire matmul_pkg::row_t   o_rd_data,
  output wire                     o_done
);

  logic              load_r;
  logic              we_a_r;
  logic              we_b_r;
  logic              read_r;
  logic              start_r;
  matmul_pkg::addr_t addr_r;
  matmul_pkg::row_t  wr_data_r;

  wire                    feed_en;
  wire                    clear;
  wire                    capture;
  wire matmul_pkg::row_t  a_lanes;
  wire matmul_pkg::row_t  b_lanes;
  wire matmul_pkg::tile_t tile;

  // host strobes and levels
  always_ff @(posedge clk) begin
    if (reset) begin
      load_r  <= 1'b0;
      we_a_r  <= 1'b0;
      we_b_r  <= 1'b0;
      read_r  <= 1'b0;
      start_r <= 1'b0;
    end else begin
      load_r  <= i_load;
      we_a_r  <= i_we_a;
      we_b_r  <= i_we_b;
      read_r  <= i_read;
      start_r <= i_start;
    end
  end

  // shared address and write data
  always_ff @(posedge clk) begin
    addr_r    <= i_addr;
    wr_data_r <= i_wr_data;
  end

  operand_feed u_feed_a (
    .clk       (clk),
    .reset     (reset),
    .i_load    (load_r),
    .i_we      (we_a_r),
    .i_wr_addr (addr_r),
    .i_wr_data (wr_data_r),
    .i_feed_en (feed_en),
    .i_run     (start_r),
    .o_lanes   (a_lanes)
  );

  operand_feed u_feed_b (
    .clk       (clk),
    .reset     (reset),
    .i_load    (load_r),
    .i_we      (we_b_r),
    .i_wr_addr (addr_r),
    .i_wr_data (wr_data_r),
    .i_feed_en (feed_en),
    .i_run     (start_r),
    .o_lanes   (b_lanes)
  );

  systolic_array u_array (
    .clk       (clk),
    .reset     (reset),
    .i_clear   (clear),
    .i_a_lanes (a_lanes),
    .i_b_lanes (b_lanes),
    .o_tile    (tile)
  );

  matmul_sequencer u_seq (
    .clk       (clk),
    .reset     (reset),
    .i_start   (start_r),
    .o_feed_en (feed_en),
    .o_clear   (clear),
    .o_capture (capture),
    .o_done    (o_done)
  );

  result_drain u_drain (
    .clk       (clk),
    .reset     (reset),
    .i_capture (capture),
    .i_tile    (tile),
    .i_read    (read_r),
    .i_rd_addr (addr_r),
    .o_rd_data (o_rd_data)
  );

endmodule

`default_nettype wire

// ==== test/matmul_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module matmul_asserts (
  input wire clk,
  input wire reset,
  input wire i_start,
  input wire i_done
);

  // input register, then the idle to run step, then the run count itself
  localparam int RISE_DELAY = matmul_pkg::DONE_CYCLES + 2;

  int unsigned fail_count = 0;

  a_done_low_in_reset : assert property (
    @(posedge clk) reset && $past(reset) |-> !i_done
  ) else begin
    $error("o_done high while reset is held");
    fail_count++;
  end

  // start low long enough to pass the input register and the FSM
  a_done_low_when_idle : assert property (
    @(posedge clk) disable iff (reset)
    !i_start && !$past(i_start) && !$past(i_start, 2) |-> !i_done
  ) else begin
    $error("o_done high while i_start is low");
    fail_count++;
  end

  a_done_holds : assert property (
    @(posedge clk) disable iff (reset)
    i_done && i_start && $past(i_start) |=> i_done
  ) else begin
    $error("o_done dropped while i_start stayed high");
    fail_count++;
  end

  a_done_latency : assert property (
    @(posedge clk) disable iff (reset)
    $rose(i_start) |-> !i_done [*RISE_DELAY] ##1 i_done
  ) else begin
    $error("o_done did not rise at the fixed count after i_start");
    fail_count++;
  end

endmodule

bind matmul_top matmul_asserts u_asserts (
  .clk     (clk),
  .reset   (reset),
  .i_start (i_start),
  .i_done  (o_done)
);

`default_nettype wire

// ==== test/tb_matmul.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_matmul;

  localparam int DIM = matmul_pkg::DIM;
  localparam int NUM_RUNS = 4;
  localparam int WATCHDOG_CYCLES = NUM_RUNS * (matmul_pkg::DONE_CYCLES + 40) + 200;
  // one edge for the input register, one for the idle to run step
  localparam int START_TO_DONE = matmul_pkg::DONE_CYCLES + 2;
  localparam int DROP_TO_IDLE = 2;
  localparam int HOLD_CYCLES = 4;

  logic              clk;
  logic              reset;
  logic              i_load;
  logic              i_we_a;
  logic              i_we_b;
  logic              i_read;
  logic              i_start;
  matmul_pkg::addr_t i_addr;
  matmul_pkg::row_t  i_wr_data;
  matmul_pkg::row_t  o_rd_data;
  logic              o_done;

  matmul_pkg::elem_t a_mat [DIM][DIM];
  matmul_pkg::elem_t b_mat [DIM][DIM];
  matmul_pkg::elem_t c_ref [DIM][DIM];

  matmul_top i_matmul_top (
    .clk       (clk),
    .reset     (reset),
    .i_load    (i_load),
    .i_we_a    (i_we_a),
    .i_we_b    (i_we_b),
    .i_read    (i_read),
    .i_start   (i_start),
    .i_addr    (i_addr),
    .i_wr_data (i_wr_data),
    .o_rd_data (o_rd_data),
    .o_done    (o_done)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  task automatic abort_run(input string what);
    $display("ERROR at %0t: %s", $time, what);
    $display("** FAIL **");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    $display("** FAIL **");
    $fatal(1, "simulation stopped");
  endtask

  function automatic void fill_random();
    for (int r = 0; r < DIM; r++) begin
      for (int c = 0; c < DIM; c++) begin
        a_mat[r][c] = matmul_pkg::elem_t'($urandom);
        b_mat[r][c] = matmul_pkg::elem_t'($urandom);
      end
    end
  endfunction

  // C[r][c] = sum over k of A[r][k] * B[k][c], wrapped to 16 bits
  function automatic void compute_reference();
    matmul_pkg::elem_t acc;
    for (int r = 0; r < DIM; r++) begin
      for (int c = 0; c < DIM; c++) begin
        acc = '0;
        for (int k = 0; k < DIM; k++) begin
          acc = acc + a_mat[r][k] * b_mat[k][c];
        end
        c_ref[r][c] = acc;
      end
    end
  endfunction

  // A word k is column k of A, B word k is row k of B
  task automatic load_operands();
    matmul_pkg::row_t word;
    for (int k = 0; k < DIM; k++) begin
      for (int r = 0; r < DIM; r++) begin
        word[r] = a_mat[r][k];
      end
      @(posedge clk);
      i_load    <= 1'b1;
      i_we_a    <= 1'b1;
      i_we_b    <= 1'b0;
      i_addr    <= matmul_pkg::addr_t'(k);
      i_wr_data <= word;
    end
    for (int k = 0; k < DIM; k++) begin
      for (int c = 0; c < DIM; c++) begin
        word[c] = b_mat[k][c];
      end
      @(posedge clk);
      i_we_a    <= 1'b0;
      i_we_b    <= 1'b1;
      i_addr    <= matmul_pkg::addr_t'(k);
      i_wr_data <= word;
    end
    @(posedge clk);
    i_load <= 1'b0;
    i_we_b <= 1'b0;
  endtask

  task automatic run_multiply();
    int edges;
    @(posedge clk);
    i_start <= 1'b1;
    edges = 0;
    do begin
      @(posedge clk);
      edges++;
      @(negedge clk);
    end while (!o_done && edges < START_TO_DONE + 20);
    if (!o_done) begin
      abort_run("timeout waiting for o_done after i_start");
    end
    assert (edges == START_TO_DONE) else report_mismatch("o_done rise edge", edges, START_TO_DONE);
    repeat (HOLD_CYCLES) begin
      @(negedge clk);
      assert (o_done == 1'b1) else report_mismatch("o_done", o_done, 1'b1);
    end
    @(posedge clk);
    i_start <= 1'b0;
    edges = 0;
    do begin
      @(posedge clk);
      edges++;
      @(negedge clk);
    end while (o_done && edges < DROP_TO_IDLE + 10);
    if (o_done) begin
      abort_run("o_done stayed high after i_start was lowered");
    end
    assert (edges == DROP_TO_IDLE) else report_mismatch("o_done fall edge", edges, DROP_TO_IDLE);
  endtask

  task automatic read_and_compare(input string label);
    matmul_pkg::row_t word;
    for (int r = 0; r < DIM; r++) begin
      @(posedge clk);
      i_read <= 1'b1;
      i_addr <= matmul_pkg::addr_t'(r);
      repeat (matmul_pkg::READ_LATENCY) @(posedge clk);
      @(negedge clk);
      word = o_rd_data;
      for (int c = 0; c < DIM; c++) begin
        assert (word[c] == c_ref[r][c]) else
          report_mismatch($sformatf("%s o_rd_data[%0d][%0d]", label, r, c), word[c], c_ref[r][c]);
      end
    end
    @(posedge clk);
    i_read <= 1'b0;
  endtask

  task automatic multiply_and_check(input string label);
    compute_reference();
    load_operands();
    run_multiply();
    read_and_compare(label);
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    abort_run("watchdog expired before the test sequence finished");
  end

  // stop as soon as a bound check on o_done fails
  initial begin
    wait (i_matmul_top.u_asserts.fail_count != 0);
    abort_run("a bound protocol assertion on o_done failed");
  end

  initial begin
    void'($urandom(32'ha393_d19f));
    reset     = 1'b1;
    i_load    = 1'b0;
    i_we_a    = 1'b0;
    i_we_b    = 1'b0;
    i_read    = 1'b0;
    i_start   = 1'b0;
    i_addr    = '0;
    i_wr_data = '0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;

    // no run yet, so done stays low
    repeat (8) begin
      @(negedge clk);
      assert (o_done == 1'b0) else report_mismatch("o_done", o_done, 1'b0);
    end

    // identity A, so C must come back as B
    fill_random();
    for (int r = 0; r < DIM; r++) begin
      for (int c = 0; c < DIM; c++) begin
        a_mat[r][c] = (r == c) ? 16'd1 : 16'd0;
      end
    end
    multiply_and_check("identity");

    fill_random();
    multiply_and_check("random");

    // second random run straight after, stale sums would show here
    fill_random();
    multiply_and_check("back_to_back");

    for (int r = 0; r < DIM; r++) begin
      for (int c = 0; c < DIM; c++) begin
        a_mat[r][c] = 16'hffff;
        b_mat[r][c] = 16'hffff;
      end
    end
    multiply_and_check("overflow");

    repeat (4) @(posedge clk);
    if (i_matmul_top.u_asserts.fail_count != 0) begin
      abort_run("a bound protocol assertion on o_done failed");
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== sources.f ====
hw/matmul_pkg.sv
hw/operand_feed.sv
hw/mac_pe.sv
hw/systolic_array.sv
hw/matmul_sequencer.sv
hw/result_drain.sv
hw/matmul_top.sv
test/matmul_asserts.sv
test/tb_matmul.sv
